/* rtl/types.sv */
// hub75 panel types
// geometry constants, framebuffer address types and pixel structs
package types;

    // panel geometry, one subpanel is half the panel height
    localparam int unsigned PIXEL_WIDTH   = 16;
    localparam int unsigned SUBPANEL_ROWS = 8;
    // bits per color channel, also the number of bit planes
    localparam int unsigned COLOR_DEPTH   = 4;
    // timeout reload for one framebuffer fetch
    localparam int unsigned FETCH_CYCLES  = 3;

    // derived widths
    localparam int unsigned COL_BITS   = $clog2(PIXEL_WIDTH);
    localparam int unsigned ROW_BITS   = $clog2(SUBPANEL_ROWS);
    localparam int unsigned PLANE_BITS = $clog2(COLOR_DEPTH);
    // one word per column per subpanel row
    localparam int unsigned MEM_DEPTH  = PIXEL_WIDTH * SUBPANEL_ROWS;

    typedef logic [COL_BITS-1:0]   col_addr_t;
    typedef logic [ROW_BITS-1:0]   row_subpanel_addr_t;
    typedef logic [PLANE_BITS-1:0] plane_t;

    // row in the upper bits, mirrored column in the lower bits
    typedef logic [ROW_BITS+COL_BITS-1:0] mem_read_addr_t;

    // one pixel, bit n of each channel belongs to plane n
    typedef struct packed {
        logic [COLOR_DEPTH-1:0] red;
        logic [COLOR_DEPTH-1:0] green;
        logic [COLOR_DEPTH-1:0] blue;
    } color_field_t;

    typedef struct packed {
        color_field_t field;
    } subpanel_pixel_t;

    // index 0 is the top subpanel, index 1 the bottom
    typedef struct packed {
        subpanel_pixel_t [1:0] subpanel;
    } mem_read_data_t;

    // panel connector pins
    typedef struct packed {
        // top subpanel serial data
        logic r1;
        logic g1;
        logic b1;
        // bottom subpanel serial data
        logic r2;
        logic g2;
        logic b2;
        // shift clock, data sampled on its rising edge
        logic sclk;
        logic lat;
        // active low, row is lit while low
        logic oe_n;
        row_subpanel_addr_t addr;
    } hub75_t;

endpackage

/* rtl/timeout.sv */
// reloadable down-counter
// start reloads VALUE, then counts down to zero and stops there
`timescale 1ns/1ns

module timeout #(
    parameter int unsigned COUNTER_WIDTH = 2,
    parameter int unsigned VALUE         = 3
) (
    input  logic                     reset,
    input  logic                     clk_in,
    input  logic                     start,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    // busy for as long as there is count left
    assign running = (counter != '0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            // a start while running simply restarts the count
            counter <= COUNTER_WIDTH'(VALUE);
        end else if (running) begin
            counter <= counter - 1'b1;
        end
    end

endmodule

/* rtl/framebuffer_ram.sv */
// framebuffer RAM
// one word holds a top and a bottom pixel, host writes, scan side reads
`timescale 1ns/1ns

module framebuffer_ram
    import types::*;
(
    input  logic           reset,
    input  logic           clk_in,
    // host side
    input  logic           wr_en,
    input  mem_read_addr_t wr_addr,
    input  mem_read_data_t wr_data,
    // fetch side
    input  logic           rd_clk_enable,
    input  mem_read_addr_t rd_addr,
    output mem_read_data_t rd_data
);

    // row-major, columns stored mirrored by the host
    mem_read_data_t mem [MEM_DEPTH];

    // host write lands on the strobe edge
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, only clocked while the fetch is active
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_clk_enable) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* rtl/framebuffer_fetch.sv */
// framebuffer fetch
// mirrors the column into a RAM address and captures both subpanel pixels
`timescale 1ns/1ns

module framebuffer_fetch
    import types::*;
(
    input  logic               reset,
    input  logic               clk_in,
    input  col_addr_t          column_address,
    input  row_subpanel_addr_t row_address,
    input  logic               pixel_load_start,
    input  mem_read_data_t     ram_data_in,
    output mem_read_addr_t     ram_address,
    output logic               ram_clk_enable,
    output color_field_t       pixeldata_top,
    output color_field_t       pixeldata_bottom
);

    logic [1:0] load_count;
    col_addr_t  column_mirrored;

    // host stores column c at PIXEL_WIDTH-1-c, so undo that here
    // column 0 then maps to the left edge of the screen
    assign column_mirrored = col_addr_t'(PIXEL_WIDTH - 1) - column_address;
    assign ram_address     = {row_address, column_mirrored};

    // count 3 on the start edge, RAM reads while nonzero
    timeout #(
        .COUNTER_WIDTH(2),
        .VALUE        (FETCH_CYCLES)
    ) u_load_timeout (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (pixel_load_start),
        .counter(load_count),
        .running(ram_clk_enable)
    );

    // RAM read happened on the edge where count went 3 -> 2
    // so rd_data is ready on the next edge
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixeldata_top    <= '0;
            pixeldata_bottom <= '0;
        end else if (load_count == 2'd2) begin
            pixeldata_top    <= ram_data_in.subpanel[0].field;
            pixeldata_bottom <= ram_data_in.subpanel[1].field;
        end
    end

endmodule

/* rtl/panel_scan.sv */
// panel scan sequencer
// walks planes, rows and columns, shifts bit-plane data and drives BCM display
`timescale 1ns/1ns

module panel_scan
    import types::*;
#(
    parameter int unsigned BASE_DISPLAY = 8
) (
    input  logic               reset,
    input  logic               clk_in,
    input  logic               scan_enable,
    output col_addr_t          column_address,
    output row_subpanel_addr_t row_address,
    output logic               pixel_load_start,
    input  color_field_t       pixeldata_top,
    input  color_field_t       pixeldata_bottom,
    output hub75_t             panel
);

    // longest lit time is on the last plane
    localparam int unsigned DISP_MAX = BASE_DISPLAY << (COLOR_DEPTH - 1);
    localparam int unsigned DISP_W   = $clog2(DISP_MAX + 1);
    localparam int unsigned WAIT_W   = $clog2(FETCH_CYCLES + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_SHIFT_LO,
        S_SHIFT_HI,
        S_BLANK,
        S_LATCH,
        S_DISPLAY
    } scan_state_t;

    scan_state_t        state;
    col_addr_t          col;
    row_subpanel_addr_t row;
    plane_t             plane;
    // cycles spent in fetch, start pulse is cycle 0
    logic [WAIT_W-1:0]  wait_cnt;
    // lit cycles left, counts down to zero
    logic [DISP_W-1:0]  disp_cnt;

    // held for the whole fetch, only change between columns or rows
    assign column_address = col;
    assign row_address    = row;

    // one-cycle pulse on the first fetch cycle
    assign pixel_load_start = (state == S_FETCH) && (wait_cnt == '0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state       <= S_IDLE;
            col         <= '0;
            row         <= '0;
            plane       <= '0;
            wait_cnt    <= '0;
            disp_cnt    <= '0;
            panel       <= '0;
            // dark until the first row is latched
            panel.oe_n  <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    // a new scan always begins at row 0, plane 0
                    if (scan_enable) begin
                        col      <= '0;
                        row      <= '0;
                        plane    <= '0;
                        wait_cnt <= '0;
                        state    <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    // fetch delay is fixed, pixeldata is valid by the last wait cycle
                    if (wait_cnt == WAIT_W'(FETCH_CYCLES)) begin
                        panel.r1 <= pixeldata_top.red[plane];
                        panel.g1 <= pixeldata_top.green[plane];
                        panel.b1 <= pixeldata_top.blue[plane];
                        panel.r2 <= pixeldata_bottom.red[plane];
                        panel.g2 <= pixeldata_bottom.green[plane];
                        panel.b2 <= pixeldata_bottom.blue[plane];
                        state    <= S_SHIFT_LO;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                S_SHIFT_LO: begin
                    // data had a full cycle of setup
                    panel.sclk <= 1'b1;
                    state      <= S_SHIFT_HI;
                end
                S_SHIFT_HI: begin
                    panel.sclk <= 1'b0;
                    if (col == col_addr_t'(PIXEL_WIDTH - 1)) begin
                        // row fully shifted, point the panel at it while still dark
                        panel.addr <= row;
                        state      <= S_BLANK;
                    end else begin
                        col      <= col + 1'b1;
                        wait_cnt <= '0;
                        state    <= S_FETCH;
                    end
                end
                S_BLANK: begin
                    panel.lat <= 1'b1;
                    state     <= S_LATCH;
                end
                S_LATCH: begin
                    panel.lat  <= 1'b0;
                    panel.oe_n <= 1'b0;
                    // binary weighted on-time, doubles per plane
                    disp_cnt   <= (DISP_W'(BASE_DISPLAY) << plane) - DISP_W'(1);
                    state      <= S_DISPLAY;
                end
                S_DISPLAY: begin
                    if (disp_cnt == '0) begin
                        panel.oe_n <= 1'b1;
                        col        <= '0;
                        wait_cnt   <= '0;
                        // plane advances after the last row, wraps with its width
                        if (row == row_subpanel_addr_t'(SUBPANEL_ROWS - 1)) begin
                            row   <= '0;
                            plane <= plane + 1'b1;
                        end else begin
                            row <= row + 1'b1;
                        end
                        // enable is only looked at on row boundaries
                        state <= scan_enable ? S_FETCH : S_IDLE;
                    end else begin
                        disp_cnt <= disp_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/hub75_top.sv */
// hub75 matrix driver top level
// host-written framebuffer, fetch path and scan sequencer to the panel pins
`timescale 1ns/1ns

module hub75_top
    import types::*;
#(
    // lit cycles for plane 0
    parameter int unsigned BASE_DISPLAY = 8
) (
    input  logic           reset,
    input  logic           clk_in,
    // host write strobe
    input  logic           wr_en,
    input  mem_read_addr_t wr_addr,
    input  mem_read_data_t wr_data,
    // level, scan stops at the next row boundary when low
    input  logic           scan_enable,
    output hub75_t         panel
);

    // scan to fetch
    col_addr_t          column_address;
    row_subpanel_addr_t row_address;
    logic               pixel_load_start;
    color_field_t       pixeldata_top;
    color_field_t       pixeldata_bottom;

    // fetch to RAM
    mem_read_addr_t     ram_address;
    logic               ram_clk_enable;
    mem_read_data_t     ram_data;

    framebuffer_ram u_ram (
        .reset        (reset),
        .clk_in       (clk_in),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_clk_enable(ram_clk_enable),
        .rd_addr      (ram_address),
        .rd_data      (ram_data)
    );

    framebuffer_fetch u_fetch (
        .reset           (reset),
        .clk_in          (clk_in),
        .column_address  (column_address),
        .row_address     (row_address),
        .pixel_load_start(pixel_load_start),
        .ram_data_in     (ram_data),
        .ram_address     (ram_address),
        .ram_clk_enable  (ram_clk_enable),
        .pixeldata_top   (pixeldata_top),
        .pixeldata_bottom(pixeldata_bottom)
    );

    panel_scan #(
        .BASE_DISPLAY(BASE_DISPLAY)
    ) u_scan (
        .reset           (reset),
        .clk_in          (clk_in),
        .scan_enable     (scan_enable),
        .column_address  (column_address),
        .row_address     (row_address),
        .pixel_load_start(pixel_load_start),
        .pixeldata_top   (pixeldata_top),
        .pixeldata_bottom(pixeldata_bottom),
        .panel           (panel)
    );

endmodule

/* sim/hub75_checker.sv */
// panel protocol checker
// bound into the driver top level, watches panel pins and the fetch RAM enable
`timescale 1ns/1ns

module hub75_checker
    import types::*;
(
    input logic   reset,
    input logic   clk_in,
    input hub75_t panel,
    input logic   pixel_load_start,
    input logic   ram_clk_enable
);

    // latch only while the panel is dark
    lat_while_dark: assert property (
        @(posedge clk_in) disable iff (reset)
        !(panel.lat && !panel.oe_n)
    ) else $error("latch pulse while the row is lit");

    // every shift clock high phase is a single cycle
    sclk_single_cycle: assert property (
        @(posedge clk_in) disable iff (reset)
        panel.sclk |=> !panel.sclk
    ) else $error("shift clock high in two consecutive cycles");

    // RAM is clocked only in the three cycles after a fetch start
    ram_enable_window: assert property (
        @(posedge clk_in) disable iff (reset)
        ram_clk_enable |-> ($past(pixel_load_start, 1) || $past(pixel_load_start, 2)
                            || $past(pixel_load_start, 3))
    ) else $error("RAM enable active more than three cycles after a fetch start");

    // row address holds while the row is lit
    addr_stable_lit: assert property (
        @(posedge clk_in) disable iff (reset)
        (!panel.oe_n && !$past(panel.oe_n)) |-> $stable(panel.addr)
    ) else $error("row address changed while the row was lit");

endmodule

bind hub75_top hub75_checker u_checker (
    .reset           (reset),
    .clk_in          (clk_in),
    .panel           (panel),
    .pixel_load_start(pixel_load_start),
    .ram_clk_enable  (ram_clk_enable)
);

/* sim/hub75_tb.sv */
// testbench for the hub75 matrix driver
// random images from an LFSR, panel pins checked against an image model
`timescale 1ns/1ns

module hub75_tb
    import types::*;
;

    localparam int          CLK_PERIOD    = 40;
    localparam int          DRIVE_DELAY   = 5;
    localparam int unsigned BASE_DISPLAY  = 8;
    localparam logic [31:0] LFSR_SEED     = 32'hcac37c16;
    // start pulse, fetch wait, sclk low, sclk high
    localparam int          COLUMN_CYCLES = 1 + FETCH_CYCLES + 2;
    // one frame shows every row once in every plane
    localparam int          FRAME_ROWS    = SUBPANEL_ROWS * COLOR_DEPTH;

    logic           reset;
    logic           clk_in;
    logic           wr_en;
    mem_read_addr_t wr_addr;
    mem_read_data_t wr_data;
    logic           scan_enable;
    hub75_t         panel;

    // copy of what the host wrote, indexed like the RAM
    mem_read_data_t     model [MEM_DEPTH];
    logic [31:0]        lfsr_state;
    // monitor state
    logic               prev_sclk;
    logic               prev_lat;
    logic               prev_oe_n;
    logic               prev_scan_enable;
    row_subpanel_addr_t exp_row;
    plane_t             exp_plane;
    int                 sclk_count;
    int                 oe_low_len;
    int                 rows_done;
    int                 err_data;
    int                 err_latch;
    int                 err_display;
    // bookkeeping of the test sequence
    int                 tests_passed;
    int                 tests_failed;
    int                 idle_errors;

    hub75_top #(
        .BASE_DISPLAY(BASE_DISPLAY)
    ) UUT (
        .reset      (reset),
        .clk_in     (clk_in),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .scan_enable(scan_enable),
        .panel      (panel)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic bit values_match(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
        bit ok;
        ok = (got == exp);
        assert (ok) else begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h (row %0d plane %0d, %0t)",
                     name, got, exp, exp_row, exp_plane, $time);
        end
        return ok;
    endfunction

    // cycles for one row in plane p
    function automatic int row_cycles(input int p);
        return PIXEL_WIDTH * COLUMN_CYCLES + 2 + (BASE_DISPLAY << p);
    endfunction

    function automatic int frame_cycles();
        int p;
        int total;
        total = 0;
        for (p = 0; p < COLOR_DEPTH; p++) begin
            total += SUBPANEL_ROWS * row_cycles(p);
        end
        return total;
    endfunction

    // fill every RAM word with random pixels, one write per cycle
    task automatic load_image();
        int a;
        logic [31:0] bits;
        for (a = 0; a < MEM_DEPTH; a++) begin
            rand_bits(24, bits);
            @(posedge clk_in);
            #DRIVE_DELAY;
            wr_en    = 1'b1;
            wr_addr  = mem_read_addr_t'(a);
            wr_data  = mem_read_data_t'(bits[23:0]);
            model[a] = mem_read_data_t'(bits[23:0]);
        end
        @(posedge clk_in);
        #DRIVE_DELAY;
        wr_en = 1'b0;
    endtask

    // panel must stay dark and quiet while the scan is stopped
    task automatic check_idle_pins(input int cycles, output int errs);
        int n;
        errs = 0;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk_in);
            if (!values_match("panel.oe_n", 32'(panel.oe_n), 32'h1)) errs++;
            if (!values_match("panel.sclk", 32'(panel.sclk), 32'h0)) errs++;
            if (!values_match("panel.lat", 32'(panel.lat), 32'h0)) errs++;
        end
    endtask

    // rows_done is counted by the monitor, the watchdog bounds this wait
    task automatic wait_rows(input int target);
        while (rows_done < target) @(posedge clk_in);
        #DRIVE_DELAY;
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    // panel monitor, sampled mid-cycle where the pins are settled
    always @(negedge clk_in) begin : panel_monitor
        mem_read_data_t word;
        logic [5:0]     exp_rgb;
        logic [5:0]     got_rgb;
        if (reset) begin
            prev_sclk        = 1'b0;
            prev_lat         = 1'b0;
            prev_oe_n        = 1'b1;
            prev_scan_enable = 1'b0;
            exp_row          = '0;
            exp_plane        = '0;
            sclk_count       = 0;
            oe_low_len       = 0;
            rows_done        = 0;
            err_data         = 0;
            err_latch        = 0;
            err_display      = 0;
        end else begin
            // a fresh scan starts over at row 0, plane 0
            if (scan_enable && !prev_scan_enable) begin
                exp_row    = '0;
                exp_plane  = '0;
                sclk_count = 0;
            end
            if (panel.sclk && !prev_sclk) begin
                assert (sclk_count < PIXEL_WIDTH) else begin
                    $display("more than %0d shift clocks before the latch", PIXEL_WIDTH);
                    err_latch++;
                end
                if (sclk_count < PIXEL_WIDTH) begin
                    // k-th shift carries the word stored at column 15-k
                    word    = model[{exp_row, col_addr_t'(PIXEL_WIDTH - 1 - sclk_count)}];
                    exp_rgb = {word.subpanel[0].field.red[exp_plane],
                               word.subpanel[0].field.green[exp_plane],
                               word.subpanel[0].field.blue[exp_plane],
                               word.subpanel[1].field.red[exp_plane],
                               word.subpanel[1].field.green[exp_plane],
                               word.subpanel[1].field.blue[exp_plane]};
                    got_rgb = {panel.r1, panel.g1, panel.b1, panel.r2, panel.g2, panel.b2};
                    if (!values_match("panel.rgb", 32'(got_rgb), 32'(exp_rgb))) err_data++;
                end
                sclk_count++;
            end
            if (panel.lat && !prev_lat) begin
                if (!values_match("sclk rises", 32'(sclk_count), PIXEL_WIDTH)) err_latch++;
                if (!values_match("panel.addr", 32'(panel.addr), 32'(exp_row))) err_latch++;
                sclk_count = 0;
            end
            assert (!(panel.lat && prev_lat)) else begin
                $display("latch stayed high for more than one cycle");
                err_latch++;
            end
            if (!panel.oe_n) oe_low_len++;
            // end of the lit time closes the row
            if (panel.oe_n && !prev_oe_n) begin
                if (!values_match("oe_n low cycles", 32'(oe_low_len),
                                  BASE_DISPLAY << exp_plane)) err_display++;
                oe_low_len = 0;
                if (exp_row == row_subpanel_addr_t'(SUBPANEL_ROWS - 1)) begin
                    exp_row = '0;
                    exp_plane++;
                end else begin
                    exp_row++;
                end
                rows_done++;
            end
            prev_sclk        = panel.sclk;
            prev_lat         = panel.lat;
            prev_oe_n        = panel.oe_n;
            prev_scan_enable = scan_enable;
        end
    end

    initial begin : watchdog
        int limit;
        // two frames and a trailing row per image, both image loads, reset and idle checks
        limit = 2 * (2 * frame_cycles() + row_cycles(COLOR_DEPTH - 1))
                + 2 * (MEM_DEPTH + 1) + 200;
        #(limit * CLK_PERIOD);
        $display("timeout: the scan did not finish its frames within %0d cycles", limit);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        int errs;
        int total;
        int base_data;
        int base_latch;
        int base_display;
        reset        = 1'b1;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        scan_enable  = 1'b0;
        lfsr_state   = LFSR_SEED;
        tests_passed = 0;
        tests_failed = 0;
        idle_errors  = 0;
        repeat (3) @(posedge clk_in);
        #DRIVE_DELAY;
        reset = 1'b0;

        // pins after reset with the scan still off
        check_idle_pins(8, errs);
        idle_errors += errs;
        report_test("reset_idle", errs);

        // first image, two full frames
        load_image();
        scan_enable = 1'b1;
        wait_rows(2 * FRAME_ROWS);
        scan_enable = 1'b0;
        report_test("serial_data", err_data);
        report_test("latch_row", err_latch);
        report_test("display_time", err_display);

        // scan finishes its row and stops, then a new image goes in
        wait_rows(2 * FRAME_ROWS + 1);
        check_idle_pins(20, errs);
        idle_errors += errs;
        load_image();
        base_data    = err_data;
        base_latch   = err_latch;
        base_display = err_display;
        scan_enable  = 1'b1;
        wait_rows(4 * FRAME_ROWS + 1);
        scan_enable = 1'b0;
        errs += (err_data - base_data) + (err_latch - base_latch)
                + (err_display - base_display);
        report_test("image_replace", errs);

        total = idle_errors + err_data + err_latch + err_display;
        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, total);
        if (tests_failed == 0 && total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
rtl/types.sv
rtl/timeout.sv
rtl/framebuffer_ram.sv
rtl/framebuffer_fetch.sv
rtl/panel_scan.sv
rtl/hub75_top.sv
sim/hub75_checker.sv
sim/hub75_tb.sv

/* Makefile */
# Verilator build and run for the hub75 matrix driver

VERILATOR  ?= verilator
TOP        := hub75_tb
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation PASSED
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

# the log decides pass or fail, not the simulator exit status
run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
